/* source/mipsPkg.sv */
package mipsPkg;

	typedef enum logic [5:0] {
		opRType = 6'h00,
		opJ     = 6'h02,
		opJal   = 6'h03,
		opBeq   = 6'h04,
		opBne   = 6'h05,
		opAddi  = 6'h08,
		opSlti  = 6'h0a,
		opAndi  = 6'h0c,
		opOri   = 6'h0d,
		opXori  = 6'h0e,
		opLui   = 6'h0f,
		opLw    = 6'h23,
		opSw    = 6'h2b
	} opcodeT;

	typedef enum logic [5:0] {
		fnSll = 6'h00,
		fnSrl = 6'h02,
		fnSra = 6'h03,
		fnJr  = 6'h08,
		fnAdd = 6'h20,
		fnSub = 6'h22,
		fnAnd = 6'h24,
		fnOr  = 6'h25,
		fnXor = 6'h26,
		fnNor = 6'h27,
		fnSlt = 6'h2a
	} functT;

	typedef enum logic [3:0] {
		aluAdd, aluSub, aluAnd, aluOr, aluXor, aluNor,
		aluSlt, aluSll, aluSrl, aluSra, aluLui
	} aluCtrlT;

	// Operation class handed from the FSM to the ALU decoder
	typedef enum logic [1:0] {addOp, subOp, functOp, immOp} aluOpT;

	typedef enum logic [1:0] {pcAluResult, pcBranch, pcJump, pcReg} pcSrcT;
	typedef enum logic [1:0] {srcAPc, srcAReg, srcAShamt} aluSrcAT;
	typedef enum logic [1:0] {srcBReg, srcBFour, srcBImm, srcBImmShift} aluSrcBT;
	typedef enum logic [1:0] {dstRt, dstRd, dstRa} regDstT;

	typedef enum logic [3:0] {
		sFetch, sDecode, sMemAdr, sMemRead, sMemWriteback, sMemWrite,
		sExecute, sAluWriteback, sBranch, sIExecute, sIWriteback,
		sJump, sJr, sJal
	} ctrlStateT;

	// Three views of the same instruction word
	typedef struct packed {
		logic [5:0] opcode;
		logic [4:0] rs;
		logic [4:0] rt;
		logic [4:0] rd;
		logic [4:0] shamt;
		logic [5:0] funct;
	} rFieldsT;

	typedef struct packed {
		logic [5:0]  opcode;
		logic [4:0]  rs;
		logic [4:0]  rt;
		logic [15:0] imm;
	} iFieldsT;

	typedef struct packed {
		logic [5:0]  opcode;
		logic [25:0] target;
	} jFieldsT;

	typedef union packed {
		rFieldsT rType;
		iFieldsT iType;
		jFieldsT jType;
	} instrWord;

endpackage

/* source/aluDecoder.sv */
`timescale 1ns/10ps

module aluDecoder import mipsPkg::*; (
	input  aluOpT      aluOp,
	input  logic [5:0] code,
	input  logic       immForm,
	output aluCtrlT    aluControl
);

	aluCtrlT functCtrl;
	aluCtrlT immCtrl;

	always_comb begin
		case (code)
			fnAdd: functCtrl = aluAdd;
			fnSub: functCtrl = aluSub;
			fnAnd: functCtrl = aluAnd;
			fnOr:  functCtrl = aluOr;
			fnXor: functCtrl = aluXor;
			fnNor: functCtrl = aluNor;
			fnSlt: functCtrl = aluSlt;
			fnSll: functCtrl = aluSll;
			fnSrl: functCtrl = aluSrl;
			fnSra: functCtrl = aluSra;
			default: functCtrl = aluAdd;
		endcase
	end

	always_comb begin
		case (code)
			opAddi: immCtrl = aluAdd;
			opSlti: immCtrl = aluSlt;
			opAndi: immCtrl = aluAnd;
			opOri:  immCtrl = aluOr;
			opXori: immCtrl = aluXor;
			opLui:  immCtrl = aluLui;
			default: immCtrl = aluAdd;
		endcase
	end

	// A code of the wrong form falls back to add
	always_comb begin
		case (aluOp)
			addOp: aluControl = aluAdd;
			subOp: aluControl = aluSub;
			functOp: aluControl = immForm ? aluAdd : functCtrl;
			default: aluControl = immForm ? immCtrl : aluAdd;
		endcase
	end

endmodule

/* source/alu.sv */
`timescale 1ns/10ps

module alu import mipsPkg::*; #(
	parameter int DataWidth = 32
) (
	input  logic [DataWidth-1:0] a,
	input  logic [DataWidth-1:0] b,
	input  aluCtrlT              aluControl,
	output logic [DataWidth-1:0] result,
	output logic                 zero
);

	localparam int ShiftBits = $clog2(DataWidth);

	logic [ShiftBits-1:0] shiftAmount;
	logic lessThan;

	// Shifts take the amount from a and the value from b
	assign shiftAmount = a[ShiftBits-1:0];
	assign lessThan = $signed(a) < $signed(b);

	always_comb begin
		case (aluControl)
			aluSub: result = a - b;
			aluAnd: result = a & b;
			aluOr:  result = a | b;
			aluXor: result = a ^ b;
			aluNor: result = ~(a | b);
			aluSlt: result = {{(DataWidth-1){1'b0}}, lessThan};
			aluSll: result = b << shiftAmount;
			aluSrl: result = b >> shiftAmount;
			aluSra: result = $signed(b) >>> shiftAmount;
			// Immediate goes to the upper half
			aluLui: result = b << (DataWidth / 2);
			default: result = a + b;
		endcase
	end

	assign zero = (result == '0);

endmodule

/* source/regFile.sv */
`timescale 1ns/10ps

module regFile #(
	parameter int DataWidth = 32
) (
	input  logic                 cclk,
	input  logic [4:0]           readAddr1,
	input  logic [4:0]           readAddr2,
	input  logic [4:0]           writeAddr,
	input  logic [DataWidth-1:0] writeData,
	input  logic                 writeEnable,
	output logic [DataWidth-1:0] readData1,
	output logic [DataWidth-1:0] readData2
);

	logic [DataWidth-1:0] regs [32];

	always_ff @(posedge cclk) begin
		if (writeEnable && (writeAddr != 5'd0)) begin
			regs[writeAddr] <= writeData;
		end
	end

	// Register 0 is hardwired to zero
	assign readData1 = (readAddr1 == 5'd0) ? '0 : regs[readAddr1];
	assign readData2 = (readAddr2 == 5'd0) ? '0 : regs[readAddr2];

endmodule

/* source/controlUnit.sv */
`timescale 1ns/10ps

module controlUnit import mipsPkg::*; (
	input  logic      cclk,
	input  logic      rstb,
	input  instrWord  instr,
	output logic      memToReg,
	output logic      iOrD,
	output regDstT    regDst,
	output pcSrcT     pcSrc,
	output aluSrcAT   aluSrcA,
	output aluSrcBT   aluSrcB,
	output logic      irWrite,
	output logic      memWrite,
	output logic      pcWrite,
	output logic [1:0] branch,
	output logic      regWrite,
	output logic      extOp,
	output aluCtrlT   aluControl
);

	ctrlStateT state;
	ctrlStateT nextState;
	aluOpT aluOp;
	logic immForm;
	logic [5:0] aluCode;
	logic [5:0] opcode;
	logic [5:0] funct;
	logic isShift;

	assign opcode = instr.iType.opcode;
	assign funct = instr.rType.funct;
	assign isShift = funct inside {fnSll, fnSrl, fnSra};

	// Logical immediates are zero extended
	assign extOp = !(opcode inside {opAndi, opOri, opXori});

	// I-type states decode the opcode, everything else the funct field
	assign immForm = (state == sIExecute) || (state == sIWriteback);
	assign aluCode = immForm ? opcode : funct;

	aluDecoder u_aluDecoder (
		.aluOp      (aluOp),
		.code       (aluCode),
		.immForm    (immForm),
		.aluControl (aluControl)
	);

	always_ff @(posedge cclk) begin
		if (!rstb) begin
			state <= sFetch;
		end else begin
			state <= nextState;
		end
	end

	always_comb begin
		case (state)
			sFetch: nextState = sDecode;
			sDecode: begin
				case (opcode)
					opLw, opSw: nextState = sMemAdr;
					opRType: nextState = sExecute;
					opBeq, opBne: nextState = sBranch;
					opAddi, opSlti, opAndi, opOri, opXori, opLui: nextState = sIExecute;
					opJ: nextState = sJump;
					opJal: nextState = sJal;
					// Unknown opcode behaves as a no-op
					default: nextState = sFetch;
				endcase
			end
			sMemAdr: nextState = (opcode == opSw) ? sMemWrite : sMemRead;
			sMemRead: nextState = sMemWriteback;
			sExecute: begin
				case (funct)
					fnJr: nextState = sJr;
					fnAdd, fnSub, fnAnd, fnOr, fnXor, fnNor, fnSlt,
					fnSll, fnSrl, fnSra: nextState = sAluWriteback;
					default: nextState = sFetch;
				endcase
			end
			sIExecute: nextState = sIWriteback;
			default: nextState = sFetch;
		endcase
	end

	always_comb begin
		memToReg = 1'b0;
		iOrD = 1'b0;
		regDst = dstRt;
		pcSrc = pcAluResult;
		aluSrcA = srcAReg;
		aluSrcB = srcBReg;
		irWrite = 1'b0;
		memWrite = 1'b0;
		pcWrite = 1'b0;
		branch = 2'b00;
		regWrite = 1'b0;
		aluOp = addOp;

		case (state)
			sFetch: begin
				// Load IR and step PC by four
				aluSrcA = srcAPc;
				aluSrcB = srcBFour;
				irWrite = 1'b1;
				pcWrite = 1'b1;
			end
			sDecode: begin
				// Branch target into ALUOut ahead of time
				aluSrcA = srcAPc;
				aluSrcB = srcBImmShift;
			end
			sMemAdr: begin
				aluSrcB = srcBImm;
			end
			sMemRead: begin
				iOrD = 1'b1;
			end
			sMemWriteback: begin
				memToReg = 1'b1;
				regWrite = 1'b1;
			end
			sMemWrite: begin
				iOrD = 1'b1;
				memWrite = 1'b1;
			end
			sExecute: begin
				aluSrcA = isShift ? srcAShamt : srcAReg;
				aluOp = functOp;
			end
			sAluWriteback: begin
				regDst = dstRd;
				regWrite = 1'b1;
			end
			sBranch: begin
				pcSrc = pcBranch;
				aluOp = subOp;
				branch = (opcode == opBne) ? 2'b10 : 2'b01;
			end
			sIExecute: begin
				aluSrcB = srcBImm;
				aluOp = immOp;
			end
			sIWriteback: begin
				regWrite = 1'b1;
			end
			sJump: begin
				pcSrc = pcJump;
				pcWrite = 1'b1;
			end
			sJr: begin
				pcSrc = pcReg;
				pcWrite = 1'b1;
			end
			sJal: begin
				// Link value is the already advanced PC
				pcSrc = pcJump;
				pcWrite = 1'b1;
				regDst = dstRa;
				regWrite = 1'b1;
			end
			default: begin
				aluOp = addOp;
			end
		endcase
	end

endmodule

/* source/dataPath.sv */
`timescale 1ns/10ps

module dataPath import mipsPkg::*; #(
	parameter int DataWidth = 32,
	parameter logic [DataWidth-1:0] ResetPc = '0
) (
	input  logic                 cclk,
	input  logic                 rstb,
	input  logic                 memToReg,
	input  logic                 iOrD,
	input  regDstT               regDst,
	input  pcSrcT                pcSrc,
	input  aluSrcAT              aluSrcA,
	input  aluSrcBT              aluSrcB,
	input  logic                 irWrite,
	input  logic                 pcWrite,
	input  logic [1:0]           branch,
	input  logic                 regWrite,
	input  logic                 extOp,
	input  aluCtrlT              aluControl,
	input  logic [DataWidth-1:0] memRdata,
	output instrWord             instr,
	output logic [DataWidth-1:0] memAddr,
	output logic [DataWidth-1:0] memWdata
);

	logic [DataWidth-1:0] pc, pcNext, dataReg, aReg, bReg, aluOut;
	logic [DataWidth-1:0] readData1, readData2, writeData;
	logic [DataWidth-1:0] srcA, srcB, aluResult;
	logic [DataWidth-1:0] immExt, shamtExt, jumpTarget;
	logic [4:0] writeAddr;
	instrWord instrReg;
	logic zero;
	logic pcEn;

	always_ff @(posedge cclk) begin
		if (!rstb) begin
			pc <= ResetPc;
		end else if (pcEn) begin
			pc <= pcNext;
		end
	end

	always_ff @(posedge cclk) begin
		if (irWrite) begin
			instrReg <= memRdata[31:0];
		end
		dataReg <= memRdata;
		aReg <= readData1;
		bReg <= readData2;
		aluOut <= aluResult;
	end

	assign instr = instrReg;
	assign memAddr = iOrD ? aluOut : pc;
	assign memWdata = bReg;

	// beq on zero, bne on nonzero
	assign pcEn = pcWrite | (branch[0] & zero) | (branch[1] & ~zero);

	assign immExt = {{(DataWidth-16){extOp & instrReg.iType.imm[15]}}, instrReg.iType.imm};
	assign shamtExt = {{(DataWidth-5){1'b0}}, instrReg.rType.shamt};
	assign jumpTarget = {pc[DataWidth-1:28], instrReg.jType.target, 2'b00};

	always_comb begin
		case (regDst)
			dstRd: writeAddr = instrReg.rType.rd;
			dstRa: writeAddr = 5'd31;
			default: writeAddr = instrReg.iType.rt;
		endcase
	end

	// jal links with PC, which already holds the return address
	assign writeData = (regDst == dstRa) ? pc : (memToReg ? dataReg : aluOut);

	regFile #(
		.DataWidth (DataWidth)
	) u_regFile (
		.cclk        (cclk),
		.readAddr1   (instrReg.rType.rs),
		.readAddr2   (instrReg.rType.rt),
		.writeAddr   (writeAddr),
		.writeData   (writeData),
		.writeEnable (regWrite),
		.readData1   (readData1),
		.readData2   (readData2)
	);

	always_comb begin
		case (aluSrcA)
			srcAPc: srcA = pc;
			srcAShamt: srcA = shamtExt;
			default: srcA = aReg;
		endcase
		case (aluSrcB)
			srcBFour: srcB = DataWidth'(4);
			srcBImm: srcB = immExt;
			srcBImmShift: srcB = immExt << 2;
			default: srcB = bReg;
		endcase
		case (pcSrc)
			pcBranch: pcNext = aluOut;
			pcJump: pcNext = jumpTarget;
			pcReg: pcNext = aReg;
			default: pcNext = aluResult;
		endcase
	end

	alu #(
		.DataWidth (DataWidth)
	) u_alu (
		.a          (srcA),
		.b          (srcB),
		.aluControl (aluControl),
		.result     (aluResult),
		.zero       (zero)
	);

endmodule

/* source/mipsCore.sv */
`timescale 1ns/10ps

module mipsCore import mipsPkg::*; #(
	parameter int DataWidth = 32,
	parameter logic [DataWidth-1:0] ResetPc = '0
) (
	input  logic                 cclk,
	input  logic                 rstb,
	input  logic [DataWidth-1:0] memRdata,
	output logic [DataWidth-1:0] memAddr,
	output logic [DataWidth-1:0] memWdata,
	output logic                 memWrite
);

	instrWord instr;
	logic memToReg, iOrD, irWrite, pcWrite, regWrite, extOp;
	logic [1:0] branch;
	regDstT regDst;
	pcSrcT pcSrc;
	aluSrcAT aluSrcA;
	aluSrcBT aluSrcB;
	aluCtrlT aluControl;

	controlUnit u_controlUnit (
		.cclk       (cclk),
		.rstb       (rstb),
		.instr      (instr),
		.memToReg   (memToReg),
		.iOrD       (iOrD),
		.regDst     (regDst),
		.pcSrc      (pcSrc),
		.aluSrcA    (aluSrcA),
		.aluSrcB    (aluSrcB),
		.irWrite    (irWrite),
		.memWrite   (memWrite),
		.pcWrite    (pcWrite),
		.branch     (branch),
		.regWrite   (regWrite),
		.extOp      (extOp),
		.aluControl (aluControl)
	);

	dataPath #(
		.DataWidth (DataWidth),
		.ResetPc   (ResetPc)
	) u_dataPath (
		.cclk       (cclk),
		.rstb       (rstb),
		.memToReg   (memToReg),
		.iOrD       (iOrD),
		.regDst     (regDst),
		.pcSrc      (pcSrc),
		.aluSrcA    (aluSrcA),
		.aluSrcB    (aluSrcB),
		.irWrite    (irWrite),
		.pcWrite    (pcWrite),
		.branch     (branch),
		.regWrite   (regWrite),
		.extOp      (extOp),
		.aluControl (aluControl),
		.memRdata   (memRdata),
		.instr      (instr),
		.memAddr    (memAddr),
		.memWdata   (memWdata)
	);

endmodule

/* bench/controlUnitProps.sv */
`timescale 1ns/10ps

module controlUnitProps import mipsPkg::*; (
	input logic       cclk,
	input logic       rstb,
	input ctrlStateT  state,
	input logic       irWrite,
	input logic       memWrite,
	input logic       regWrite,
	input logic [1:0] branch
);

	// Number of failed properties
	int failures = 0;

	// A store and a register writeback never share a cycle
	noStoreWithWriteback: assert property (@(posedge cclk) disable iff (!rstb)
		!(memWrite && regWrite))
	else begin
		$error("memWrite and regWrite are high in the same cycle");
		failures++;
	end

	irWriteOnlyInFetch: assert property (@(posedge cclk) disable iff (!rstb)
		irWrite == (state == sFetch))
	else begin
		$error("irWrite does not follow the fetch state");
		failures++;
	end

	// First cycle out of reset is a clean fetch
	quietAfterReset: assert property (@(posedge cclk)
		$rose(rstb) |-> (!memWrite && !regWrite && branch == 2'b00))
	else begin
		$error("memWrite, regWrite or branch active in the first cycle after reset");
		failures++;
	end

endmodule

bind controlUnit controlUnitProps u_controlUnitProps (
	.cclk     (cclk),
	.rstb     (rstb),
	.state    (state),
	.irWrite  (irWrite),
	.memWrite (memWrite),
	.regWrite (regWrite),
	.branch   (branch)
);

/* bench/mipsCoreTb.sv */
`timescale 1ns/10ps

module mipsCoreTb import mipsPkg::*; ();

	localparam int MemWords = 256;
	localparam int NumChecks = 22;
	localparam logic [31:0] DataBase = 32'h0000_0300;
	// Word 58 holds the jal
	localparam logic [31:0] JalAddr = 32'd58 * 32'd4;
	// Sum of per-instruction cycles along the executed path
	localparam int ProgramCycles = 235;
	localparam int WatchdogCycles = 16 + 5 * ProgramCycles;

	logic cclk;
	logic rstb;
	logic [31:0] memRdata;
	logic [31:0] memAddr;
	logic [31:0] memWdata;
	logic memWrite;

	logic [31:0] mem [MemWords];
	logic [31:0] checkAddr [NumChecks];
	logic [31:0] checkData [NumChecks];
	logic checkSeen [NumChecks];
	int numChecks;
	int loadIdx;
	int storeCount;

	mipsCore #(
		.DataWidth (32),
		.ResetPc   (32'h0)
	) u_mipsCore (
		.cclk     (cclk),
		.rstb     (rstb),
		.memRdata (memRdata),
		.memAddr  (memAddr),
		.memWdata (memWdata),
		.memWrite (memWrite)
	);

	always #5 cclk = ~cclk;

	// Word memory read in the same cycle and written at the clock edge
	assign memRdata = mem[memAddr[9:2]];

	always @(posedge cclk) begin
		if (memWrite) begin
			mem[memAddr[9:2]] <= memWdata;
		end
	end

	function automatic logic [31:0] rFormat(input logic [5:0] funct, input logic [4:0] rs,
		input logic [4:0] rt, input logic [4:0] rd, input logic [4:0] shamt);
		return {6'h00, rs, rt, rd, shamt, funct};
	endfunction

	function automatic logic [31:0] iFormat(input logic [5:0] opcode, input logic [4:0] rs,
		input logic [4:0] rt, input logic [15:0] imm);
		return {opcode, rs, rt, imm};
	endfunction

	function automatic logic [31:0] jFormat(input logic [5:0] opcode,
		input logic [25:0] target);
		return {opcode, target};
	endfunction

	function automatic int checkIndex(input logic [31:0] addr);
		int found;
		found = -1;
		for (int k = 0; k < numChecks; k++) begin
			if (checkAddr[k] == addr) begin
				found = k;
			end
		end
		return found;
	endfunction

	// Each check address counts once toward the end of the run
	always @(posedge cclk) begin
		if (rstb && memWrite && checkIndex(memAddr) >= 0) begin
			if (!checkSeen[checkIndex(memAddr)]) begin
				checkSeen[checkIndex(memAddr)] <= 1'b1;
				storeCount <= storeCount + 1;
			end
		end
	end

	task automatic place(input logic [31:0] word);
		mem[loadIdx] = word;
		loadIdx++;
	endtask

	task automatic expectStore(input logic [7:0] offset, input logic [31:0] value);
		checkAddr[numChecks] = DataBase + offset;
		checkData[numChecks] = value;
		checkSeen[numChecks] = 1'b0;
		numChecks++;
	endtask

	task automatic loadProgram();
		int i;
		// Opcode 0x3f is unsupported, so stray fetches act as no-ops
		for (i = 0; i < MemWords; i++) begin
			mem[i] = 32'hfc00_0000 | i;
		end
		loadIdx = 0;
		place(iFormat(opAddi, 5'd0, 5'd20, 16'h0300));
		// R-type on r1 = 0x12345678 and r2 = -0x1235
		place(iFormat(opLui, 5'd0, 5'd1, 16'h1234));
		place(iFormat(opAddi, 5'd1, 5'd1, 16'h5678));
		place(iFormat(opAddi, 5'd0, 5'd2, 16'hedcb));
		place(rFormat(fnAdd, 5'd1, 5'd2, 5'd3, 5'd0));
		place(iFormat(opSw, 5'd20, 5'd3, 16'h0000));
		place(rFormat(fnSub, 5'd1, 5'd2, 5'd3, 5'd0));
		place(iFormat(opSw, 5'd20, 5'd3, 16'h0004));
		place(rFormat(fnAnd, 5'd1, 5'd2, 5'd3, 5'd0));
		place(iFormat(opSw, 5'd20, 5'd3, 16'h0008));
		place(rFormat(fnOr, 5'd1, 5'd2, 5'd3, 5'd0));
		place(iFormat(opSw, 5'd20, 5'd3, 16'h000c));
		place(rFormat(fnXor, 5'd1, 5'd2, 5'd3, 5'd0));
		place(iFormat(opSw, 5'd20, 5'd3, 16'h0010));
		place(rFormat(fnNor, 5'd1, 5'd2, 5'd3, 5'd0));
		place(iFormat(opSw, 5'd20, 5'd3, 16'h0014));
		place(rFormat(fnSlt, 5'd2, 5'd1, 5'd3, 5'd0));
		place(iFormat(opSw, 5'd20, 5'd3, 16'h0018));
		place(rFormat(fnSlt, 5'd1, 5'd2, 5'd3, 5'd0));
		place(iFormat(opSw, 5'd20, 5'd3, 16'h001c));
		// Shifts of a negative word
		place(iFormat(opLui, 5'd0, 5'd6, 16'h8765));
		place(iFormat(opAddi, 5'd6, 5'd6, 16'h4321));
		place(rFormat(fnSll, 5'd0, 5'd6, 5'd3, 5'd4));
		place(iFormat(opSw, 5'd20, 5'd3, 16'h0020));
		place(rFormat(fnSrl, 5'd0, 5'd6, 5'd3, 5'd8));
		place(iFormat(opSw, 5'd20, 5'd3, 16'h0024));
		place(rFormat(fnSra, 5'd0, 5'd6, 5'd3, 5'd8));
		place(iFormat(opSw, 5'd20, 5'd3, 16'h0028));
		// Sign versus zero extension
		place(iFormat(opAddi, 5'd1, 5'd3, 16'hfff0));
		place(iFormat(opSw, 5'd20, 5'd3, 16'h002c));
		place(iFormat(opSlti, 5'd0, 5'd3, 16'hffff));
		place(iFormat(opSw, 5'd20, 5'd3, 16'h0030));
		place(iFormat(opAndi, 5'd2, 5'd3, 16'h8f0f));
		place(iFormat(opSw, 5'd20, 5'd3, 16'h0034));
		place(iFormat(opOri, 5'd1, 5'd3, 16'h8001));
		place(iFormat(opSw, 5'd20, 5'd3, 16'h0038));
		place(iFormat(opXori, 5'd1, 5'd3, 16'hf0f0));
		place(iFormat(opSw, 5'd20, 5'd3, 16'h003c));
		// Store, load back, store again
		place(iFormat(opSw, 5'd20, 5'd6, 16'h0040));
		place(iFormat(opLw, 5'd20, 5'd15, 16'h0040));
		place(iFormat(opSw, 5'd20, 5'd15, 16'h0044));
		// Each addi that runs sets its own bit of the marker in r16
		place(iFormat(opAddi, 5'd0, 5'd16, 16'h0000));
		place(iFormat(opAddi, 5'd0, 5'd17, 16'h0005));
		place(iFormat(opAddi, 5'd0, 5'd18, 16'h0005));
		place(iFormat(opAddi, 5'd0, 5'd19, 16'h0007));
		place(iFormat(opBeq, 5'd17, 5'd18, 16'h0001));
		place(iFormat(opAddi, 5'd16, 5'd16, 16'h0001));
		place(iFormat(opBeq, 5'd17, 5'd19, 16'h0001));
		place(iFormat(opAddi, 5'd16, 5'd16, 16'h0002));
		place(iFormat(opBne, 5'd17, 5'd19, 16'h0001));
		place(iFormat(opAddi, 5'd16, 5'd16, 16'h0004));
		place(iFormat(opBne, 5'd17, 5'd18, 16'h0001));
		place(iFormat(opAddi, 5'd16, 5'd16, 16'h0008));
		place(iFormat(opSw, 5'd20, 5'd16, 16'h0048));
		// Word 55 jumps over word 56
		place(iFormat(opAddi, 5'd0, 5'd21, 16'h0001));
		place(jFormat(opJ, 26'd57));
		place(iFormat(opAddi, 5'd21, 5'd21, 16'h0010));
		place(iFormat(opSw, 5'd20, 5'd21, 16'h004c));
		place(jFormat(opJal, 26'd62));
		place(iFormat(opSw, 5'd20, 5'd31, 16'h0050));
		place(iFormat(opSw, 5'd20, 5'd22, 16'h0054));
		// Park here once done
		place(jFormat(opJ, 26'd61));
		// Subroutine at word 62
		place(iFormat(opAddi, 5'd0, 5'd22, 16'h003c));
		place(rFormat(fnJr, 5'd31, 5'd0, 5'd0, 5'd0));
	endtask

	task automatic loadChecks();
		numChecks = 0;
		expectStore(8'h00, 32'h1234_4443);
		expectStore(8'h04, 32'h1234_68ad);
		expectStore(8'h08, 32'h1234_4448);
		expectStore(8'h0c, 32'hffff_fffb);
		expectStore(8'h10, 32'hedcb_bbb3);
		expectStore(8'h14, 32'h0000_0004);
		expectStore(8'h18, 32'h0000_0001);
		expectStore(8'h1c, 32'h0000_0000);
		expectStore(8'h20, 32'h7654_3210);
		expectStore(8'h24, 32'h0087_6543);
		expectStore(8'h28, 32'hff87_6543);
		expectStore(8'h2c, 32'h1234_5668);
		expectStore(8'h30, 32'h0000_0000);
		expectStore(8'h34, 32'h0000_8d0b);
		expectStore(8'h38, 32'h1234_d679);
		expectStore(8'h3c, 32'h1234_a688);
		expectStore(8'h40, 32'h8765_4321);
		expectStore(8'h44, 32'h8765_4321);
		// Taken beq and bne skip 1 and 4
		expectStore(8'h48, 32'h0000_000a);
		expectStore(8'h4c, 32'h0000_0001);
		expectStore(8'h50, JalAddr + 32'd4);
		expectStore(8'h54, 32'h0000_003c);
	endtask

	storeAddrChecked: assert property (@(posedge cclk) disable iff (!rstb)
		memWrite |-> checkIndex(memAddr) >= 0)
	else begin
		$display("[ERROR] %0t memAddr: expected a check address, got 0x%08h",
			$time, $sampled(memAddr));
		$display("STATUS: FAIL");
		$fatal(1);
	end

	storeDataChecked: assert property (@(posedge cclk) disable iff (!rstb)
		(memWrite && checkIndex(memAddr) >= 0) |->
		memWdata == checkData[checkIndex(memAddr)])
	else begin
		$display("[ERROR] %0t memWdata at 0x%08h: expected 0x%08h, got 0x%08h", $time,
			$sampled(memAddr), checkData[checkIndex($sampled(memAddr))],
			$sampled(memWdata));
		$display("STATUS: FAIL");
		$fatal(1);
	end

	always @(negedge cclk) begin
		if (u_mipsCore.u_controlUnit.u_controlUnitProps.failures != 0) begin
			$display("A controller property failed, see the assertion message above");
			$display("STATUS: FAIL");
			$fatal(1);
		end
	end

	initial begin
		repeat (WatchdogCycles) @(posedge cclk);
		$display("Timeout: the program did not reach its final store in %0d cycles",
			WatchdogCycles);
		$display("STATUS: FAIL");
		$fatal(1);
	end

	initial begin
		cclk = 1'b0;
		rstb = 1'b0;
		storeCount = 0;
		loadProgram();
		loadChecks();
		repeat (16) @(posedge cclk);
		rstb <= 1'b1;
		wait (storeCount == numChecks);
		// Give the checks on the last store time to run
		repeat (2) @(posedge cclk);
		if (u_mipsCore.u_controlUnit.u_controlUnitProps.failures != 0) begin
			$display("Controller properties failed during the run");
			$display("STATUS: FAIL");
			$fatal(1);
		end else begin
			$display("STATUS: PASS");
			$finish;
		end
	end

endmodule

/* sources.f */
source/mipsPkg.sv
source/aluDecoder.sv
source/alu.sv
source/regFile.sv
source/controlUnit.sv
source/dataPath.sv
source/mipsCore.sv
bench/controlUnitProps.sv
bench/mipsCoreTb.sv

/* Bender.yml */
package:
  name: mipscore

dependencies: {}

sources:
  - source/mipsPkg.sv
  - source/aluDecoder.sv
  - source/alu.sv
  - source/regFile.sv
  - source/controlUnit.sv
  - source/dataPath.sv
  - source/mipsCore.sv
  - target: simulation
    files:
      - bench/controlUnitProps.sv
      - bench/mipsCoreTb.sv
